// ==== common/bridge_params.svh ====
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// AXI-Lite side widths
`define AXIL_ADDR_W 12
`define AXIL_DATA_W 16
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// byte address bits dropped to get a word address
`define WORD_LSB 1

// SRAM geometry
`define SRAM_ADDR_W (`AXIL_ADDR_W - `WORD_LSB)
`define SRAM_DEPTH (1 << `SRAM_ADDR_W)

`endif

// ==== common/axil_pkg.sv ====
`include "bridge_params.svh"

// AXI-Lite side types
package axil_pkg;

  // byte address
  typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;

  // data word
  typedef logic [`AXIL_DATA_W-1:0] axil_data_t;

  // one enable per byte lane
  typedef logic [`AXIL_STRB_W-1:0] axil_strb_t;

  // response codes, only OKAY is ever returned
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

endpackage

// ==== common/sram_pkg.sv ====
`include "bridge_params.svh"

// SRAM side types
package sram_pkg;

  // word address
  typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;

  // single command port, reads leave wdata and strb at zero
  typedef struct packed {
    sram_addr_t           addr;
    logic                 we;
    axil_pkg::axil_data_t wdata;
    axil_pkg::axil_strb_t strb;
  } sram_cmd_t;

  // read response
  typedef struct packed {
    axil_pkg::axil_data_t rdata;
  } sram_rsp_t;

endpackage

// ==== axil_sram_bridge/axil_write_path.sv ====
`timescale 1ns/1ps
`include "bridge_params.svh"

module axil_write_path (
  input  logic                 clk,
  input  logic                 rst_n,

  input  axil_pkg::axil_addr_t i_awaddr,
  input  logic                 i_awvalid,
  output logic                 o_awready,
  input  axil_pkg::axil_data_t i_wdata,
  input  axil_pkg::axil_strb_t i_wstrb,
  input  logic                 i_wvalid,
  output logic                 o_wready,
  output axil_pkg::axil_resp_e o_bresp,
  output logic                 o_bvalid,
  input  logic                 i_bready,

  output logic                 o_cmd_valid,
  input  logic                 i_cmd_ready,
  output sram_pkg::sram_cmd_t  o_cmd
);
  import axil_pkg::*;
  import sram_pkg::*;

  logic       aw_held;
  logic       w_held;
  logic       bvalid_q;
  sram_addr_t addr_q;
  axil_data_t data_q;
  axil_strb_t strb_q;

  logic       aw_xfer;
  logic       w_xfer;
  logic       cmd_xfer;
  logic       b_xfer;

  assign o_awready = !aw_held;
  assign o_wready  = !w_held;
  assign aw_xfer   = i_awvalid && o_awready;
  assign w_xfer    = i_wvalid && o_wready;

  // one command once both halves are in, dropped when B goes up
  assign o_cmd_valid = aw_held && w_held && !bvalid_q;
  assign cmd_xfer    = o_cmd_valid && i_cmd_ready;
  assign b_xfer      = bvalid_q && i_bready;

  assign o_bvalid = bvalid_q;
  assign o_bresp  = RESP_OKAY;

  always_comb begin
    o_cmd       = '0;
    o_cmd.addr  = addr_q;
    o_cmd.we    = 1'b1;
    o_cmd.wdata = data_q;
    o_cmd.strb  = strb_q;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (aw_xfer) begin
        aw_held <= 1'b1;
      end
      if (w_xfer) begin
        w_held <= 1'b1;
      end
      if (cmd_xfer) begin
        bvalid_q <= 1'b1;
      end
      // both channels reopen only once B is taken
      if (b_xfer) begin
        bvalid_q <= 1'b0;
        aw_held  <= 1'b0;
        w_held   <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_xfer) begin
      addr_q <= i_awaddr[`AXIL_ADDR_W-1:`WORD_LSB];
    end
    if (w_xfer) begin
      data_q <= i_wdata;
      strb_q <= i_wstrb;
    end
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_bvalid && !i_bready |=> o_bvalid);

endmodule

// ==== axil_sram_bridge/axil_read_path.sv ====
`timescale 1ns/1ps
`include "bridge_params.svh"

module axil_read_path (
  input  logic                 clk,
  input  logic                 rst_n,

  input  axil_pkg::axil_addr_t i_araddr,
  input  logic                 i_arvalid,
  output logic                 o_arready,
  output axil_pkg::axil_data_t o_rdata,
  output axil_pkg::axil_resp_e o_rresp,
  output logic                 o_rvalid,
  input  logic                 i_rready,

  output logic                 o_cmd_valid,
  input  logic                 i_cmd_ready,
  output sram_pkg::sram_cmd_t  o_cmd,
  input  logic                 i_rsp_valid,
  output logic                 o_rsp_ready,
  input  sram_pkg::sram_rsp_t  i_rsp
);
  import axil_pkg::*;
  import sram_pkg::*;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_CMD,
    RD_WAIT
  } rd_state_e;

  rd_state_e  state_q;
  logic       rvalid_q;
  sram_addr_t addr_q;
  axil_data_t rdata_q;

  logic       ar_xfer;
  logic       rsp_xfer;

  // idle means no access and no R pending
  assign o_arready   = (state_q == RD_IDLE) && !rvalid_q;
  assign ar_xfer     = i_arvalid && o_arready;
  assign o_cmd_valid = (state_q == RD_CMD);
  assign o_rsp_ready = (state_q == RD_WAIT) && !rvalid_q;
  assign rsp_xfer    = i_rsp_valid && o_rsp_ready;

  assign o_rvalid = rvalid_q;
  assign o_rdata  = rdata_q;
  assign o_rresp  = RESP_OKAY;

  always_comb begin
    o_cmd      = '0;
    o_cmd.addr = addr_q;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= RD_IDLE;
      rvalid_q <= 1'b0;
    end else begin
      case (state_q)
        RD_IDLE: begin
          if (ar_xfer) begin
            state_q <= RD_CMD;
          end
        end
        RD_CMD: begin
          if (i_cmd_ready) begin
            state_q <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          if (rsp_xfer) begin
            state_q  <= RD_IDLE;
            rvalid_q <= 1'b1;
          end
        end
        default: state_q <= RD_IDLE;
      endcase
      if (rvalid_q && i_rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_xfer) begin
      addr_q <= i_araddr[`AXIL_ADDR_W-1:`WORD_LSB];
    end
    if (rsp_xfer) begin
      rdata_q <= i_rsp.rdata;
    end
  end

  a_rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
    o_rvalid && !i_rready |=> $stable(o_rdata));

endmodule

// ==== axil_sram_bridge/sram_arbiter.sv ====
`timescale 1ns/1ps

module sram_arbiter (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                i_rd_valid,
  input  sram_pkg::sram_cmd_t i_rd_cmd,
  output logic                o_rd_ready,

  input  logic                i_wr_valid,
  input  sram_pkg::sram_cmd_t i_wr_cmd,
  output logic                o_wr_ready,

  output logic                o_cmd_valid,
  output sram_pkg::sram_cmd_t o_cmd,
  input  logic                i_cmd_ready
);

  typedef enum logic [1:0] {
    GNT_IDLE,
    GNT_READ,
    GNT_WRITE
  } gnt_e;

  gnt_e gnt_q;
  gnt_e gnt_pick;
  gnt_e gnt_cur;
  logic pri_rd_q;
  logic xfer;

  // fair pick, the side not served last goes first
  always_comb begin
    if (pri_rd_q) begin
      if (i_rd_valid) begin
        gnt_pick = GNT_READ;
      end else if (i_wr_valid) begin
        gnt_pick = GNT_WRITE;
      end else begin
        gnt_pick = GNT_IDLE;
      end
    end else begin
      if (i_wr_valid) begin
        gnt_pick = GNT_WRITE;
      end else if (i_rd_valid) begin
        gnt_pick = GNT_READ;
      end else begin
        gnt_pick = GNT_IDLE;
      end
    end
  end

  // a stalled grant sticks until its command is taken
  assign gnt_cur = (gnt_q != GNT_IDLE) ? gnt_q : gnt_pick;

  always_comb begin
    o_cmd_valid = 1'b0;
    o_cmd       = '0;
    o_rd_ready  = 1'b0;
    o_wr_ready  = 1'b0;
    case (gnt_cur)
      GNT_READ: begin
        o_cmd_valid = i_rd_valid;
        o_cmd       = i_rd_cmd;
        o_rd_ready  = i_cmd_ready;
      end
      GNT_WRITE: begin
        o_cmd_valid = i_wr_valid;
        o_cmd       = i_wr_cmd;
        o_wr_ready  = i_cmd_ready;
      end
      default: begin
        o_cmd_valid = 1'b0;
      end
    endcase
  end

  assign xfer = o_cmd_valid && i_cmd_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gnt_q    <= GNT_IDLE;
      pri_rd_q <= 1'b0;
    end else begin
      gnt_q <= xfer ? GNT_IDLE : gnt_cur;
      // reads next after a write, writes next after a read
      if (xfer) begin
        pri_rd_q <= (gnt_cur == GNT_WRITE);
      end
    end
  end

  a_one_ready: assert property (@(posedge clk) disable iff (!rst_n)
    !(o_rd_ready && o_wr_ready));

  a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
    o_cmd_valid && !i_cmd_ready |=> o_cmd_valid && $stable(o_cmd));

endmodule

// ==== hdl/sram_model.sv ====
`timescale 1ns/1ps
`include "bridge_params.svh"

module sram_model (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                i_cmd_valid,
  output logic                o_cmd_ready,
  input  sram_pkg::sram_cmd_t i_cmd,

  output logic                o_rsp_valid,
  input  logic                i_rsp_ready,
  output sram_pkg::sram_rsp_t o_rsp
);
  import axil_pkg::*;

  axil_data_t mem [0:`SRAM_DEPTH-1];

  logic rsp_valid_q;
  logic cmd_xfer;

  // no new access while a read result is still waiting
  assign o_cmd_ready = !rsp_valid_q;
  assign cmd_xfer    = i_cmd_valid && o_cmd_ready;
  assign o_rsp_valid = rsp_valid_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      if (cmd_xfer && !i_cmd.we) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_valid_q && i_rsp_ready) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  // writes land on the command edge, byte lanes by strobe
  always_ff @(posedge clk) begin
    if (cmd_xfer) begin
      if (i_cmd.we) begin
        for (int b = 0; b < `AXIL_STRB_W; b++) begin
          if (i_cmd.strb[b]) begin
            mem[i_cmd.addr][b*8 +: 8] <= i_cmd.wdata[b*8 +: 8];
          end
        end
      end else begin
        o_rsp.rdata <= mem[i_cmd.addr];
      end
    end
  end

endmodule

// ==== hdl/axil_sram_top.sv ====
`timescale 1ns/1ps

module axil_sram_top (
  input  logic                 clk,
  input  logic                 rst_n,

  input  axil_pkg::axil_addr_t i_awaddr,
  input  logic                 i_awvalid,
  output logic                 o_awready,
  input  axil_pkg::axil_data_t i_wdata,
  input  axil_pkg::axil_strb_t i_wstrb,
  input  logic                 i_wvalid,
  output logic                 o_wready,
  output axil_pkg::axil_resp_e o_bresp,
  output logic                 o_bvalid,
  input  logic                 i_bready,

  input  axil_pkg::axil_addr_t i_araddr,
  input  logic                 i_arvalid,
  output logic                 o_arready,
  output axil_pkg::axil_data_t o_rdata,
  output axil_pkg::axil_resp_e o_rresp,
  output logic                 o_rvalid,
  input  logic                 i_rready
);
  import sram_pkg::*;

  // path to arbiter
  logic      wr_cmd_valid;
  logic      wr_cmd_ready;
  sram_cmd_t wr_cmd;
  logic      rd_cmd_valid;
  logic      rd_cmd_ready;
  sram_cmd_t rd_cmd;

  // arbiter to memory, and read data back
  logic      sram_cmd_valid;
  logic      sram_cmd_ready;
  sram_cmd_t sram_cmd;
  logic      sram_rsp_valid;
  logic      sram_rsp_ready;
  sram_rsp_t sram_rsp;

  axil_write_path u_write_path (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_awaddr   (i_awaddr),
    .i_awvalid  (i_awvalid),
    .o_awready  (o_awready),
    .i_wdata    (i_wdata),
    .i_wstrb    (i_wstrb),
    .i_wvalid   (i_wvalid),
    .o_wready   (o_wready),
    .o_bresp    (o_bresp),
    .o_bvalid   (o_bvalid),
    .i_bready   (i_bready),
    .o_cmd_valid(wr_cmd_valid),
    .i_cmd_ready(wr_cmd_ready),
    .o_cmd      (wr_cmd)
  );

  axil_read_path u_read_path (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_araddr   (i_araddr),
    .i_arvalid  (i_arvalid),
    .o_arready  (o_arready),
    .o_rdata    (o_rdata),
    .o_rresp    (o_rresp),
    .o_rvalid   (o_rvalid),
    .i_rready   (i_rready),
    .o_cmd_valid(rd_cmd_valid),
    .i_cmd_ready(rd_cmd_ready),
    .o_cmd      (rd_cmd),
    .i_rsp_valid(sram_rsp_valid),
    .o_rsp_ready(sram_rsp_ready),
    .i_rsp      (sram_rsp)
  );

  sram_arbiter u_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_rd_valid (rd_cmd_valid),
    .i_rd_cmd   (rd_cmd),
    .o_rd_ready (rd_cmd_ready),
    .i_wr_valid (wr_cmd_valid),
    .i_wr_cmd   (wr_cmd),
    .o_wr_ready (wr_cmd_ready),
    .o_cmd_valid(sram_cmd_valid),
    .o_cmd      (sram_cmd),
    .i_cmd_ready(sram_cmd_ready)
  );

  sram_model u_sram (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_cmd_valid(sram_cmd_valid),
    .o_cmd_ready(sram_cmd_ready),
    .i_cmd      (sram_cmd),
    .o_rsp_valid(sram_rsp_valid),
    .i_rsp_ready(sram_rsp_ready),
    .o_rsp      (sram_rsp)
  );

endmodule

// ==== sim/tb_axil_sram.sv ====
`timescale 1ns/1ps
`include "bridge_params.svh"

module tb_axil_sram;
  import axil_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 1000;
  localparam int WATCHDOG_NS     = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD;

  logic       clk;
  logic       rst_n;
  axil_addr_t i_awaddr;
  logic       i_awvalid;
  logic       o_awready;
  axil_data_t i_wdata;
  axil_strb_t i_wstrb;
  logic       i_wvalid;
  logic       o_wready;
  axil_resp_e o_bresp;
  logic       o_bvalid;
  logic       i_bready;
  axil_addr_t i_araddr;
  logic       i_arvalid;
  logic       o_arready;
  axil_data_t o_rdata;
  axil_resp_e o_rresp;
  logic       o_rvalid;
  logic       i_rready;

  // expected contents with one entry per SRAM word
  axil_data_t ref_mem [0:`SRAM_DEPTH-1];

  int seed         = 22;
  int errors       = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int b_count      = 0;

  axil_sram_top UUT (
    .clk(clk), .rst_n(rst_n),
    .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
    .i_wdata(i_wdata), .i_wstrb(i_wstrb), .i_wvalid(i_wvalid), .o_wready(o_wready),
    .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
    .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
    .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_fail(input string msg);
    errors++;
    $display("Fail at time %0t: %s", $time, msg);
  endtask

  // handshake rules on B and R
  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp))
    else report_fail("B response dropped or changed before bready");
  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp))
    else report_fail("R response dropped or changed before rready");
  b_okay: assert property (@(posedge clk) disable iff (!rst_n)
    o_bvalid |-> o_bresp == RESP_OKAY)
    else report_fail("bresp is not OKAY");
  r_okay: assert property (@(posedge clk) disable iff (!rst_n)
    o_rvalid |-> o_rresp == RESP_OKAY)
    else report_fail("rresp is not OKAY");

  always @(posedge clk) begin
    if (rst_n && o_bvalid && i_bready) begin
      b_count <= b_count + 1;
    end
  end

  function automatic int word_index(input axil_addr_t addr);
    return addr >> `WORD_LSB;
  endfunction

  // new bytes where the strobe is set and old bytes elsewhere
  function automatic axil_data_t merge_bytes(input axil_data_t old_word,
                                             input axil_data_t new_word,
                                             input axil_strb_t strb);
    axil_data_t res;
    int         b;
    res = old_word;
    for (b = 0; b < `AXIL_STRB_W; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // roughly three ready cycles in four when gaps are on
  function automatic logic draw_ready(input bit gaps);
    if (!gaps) begin
      return 1'b1;
    end
    return (($random(seed) & 3) != 0);
  endfunction

  task automatic write_word(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb, input int aw_delay,
                            input int w_delay, input bit gaps);
    fork
      begin
        repeat (aw_delay) @(negedge clk);
        i_awaddr  = addr;
        i_awvalid = 1'b1;
        while (!o_awready) @(negedge clk);
        @(negedge clk);
        i_awvalid = 1'b0;
      end
      begin
        repeat (w_delay) @(negedge clk);
        i_wdata  = data;
        i_wstrb  = strb;
        i_wvalid = 1'b1;
        while (!o_wready) @(negedge clk);
        @(negedge clk);
        i_wvalid = 1'b0;
      end
    join
    i_bready = draw_ready(gaps);
    while (!(o_bvalid && i_bready)) begin
      @(negedge clk);
      i_bready = draw_ready(gaps);
    end
    @(negedge clk);
    i_bready = 1'b0;
    ref_mem[word_index(addr)] = merge_bytes(ref_mem[word_index(addr)], data, strb);
  endtask

  task automatic check_read(input axil_addr_t addr, input bit gaps);
    axil_data_t got;
    axil_data_t exp;
    i_araddr  = addr;
    i_arvalid = 1'b1;
    while (!o_arready) @(negedge clk);
    @(negedge clk);
    i_arvalid = 1'b0;
    i_rready  = draw_ready(gaps);
    while (!(o_rvalid && i_rready)) begin
      @(negedge clk);
      i_rready = draw_ready(gaps);
    end
    got = o_rdata;
    exp = ref_mem[word_index(addr)];
    @(negedge clk);
    i_rready = 1'b0;
    assert (got === exp)
      else report_fail($sformatf("read of %h returned %h, expected %h", addr, got, exp));
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_before);
    end else begin
      $display("test %0d %s: passed", tests_run, name);
    end
  endtask

  initial begin : main
    axil_addr_t addr;
    axil_data_t data;
    axil_addr_t waddr;
    axil_data_t wdat;
    axil_strb_t wstrb;
    int         err_start;
    int         n0;
    int         i;
    int         j;
    int         k;
    rst_n     = 1'b0;
    i_awaddr  = '0;
    i_awvalid = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_wvalid  = 1'b0;
    i_bready  = 1'b0;
    i_araddr  = '0;
    i_arvalid = 1'b0;
    i_rready  = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    err_start = errors;
    assert (!o_bvalid && !o_rvalid) else report_fail("bvalid or rvalid high after reset");
    assert (o_awready && o_wready && o_arready)
      else report_fail("awready, wready or arready low after reset");
    finish_test("reset values", err_start);

    err_start = errors;
    addr = $random(seed);
    data = $random(seed);
    write_word(addr, data, '1, 0, 0, 1'b0);
    check_read(addr, 1'b0);
    finish_test("full write then read", err_start);

    err_start = errors;
    addr = $random(seed);
    data = $random(seed);
    write_word(addr, data, '1, 0, 0, 1'b0);
    data = $random(seed);
    write_word(addr, data, 2'b01, 0, 0, 1'b0);
    check_read(addr, 1'b0);
    data = $random(seed);
    write_word(addr, data, 2'b10, 0, 0, 1'b0);
    check_read(addr, 1'b0);
    finish_test("partial strobe merge", err_start);

    err_start = errors;
    addr = $random(seed);
    data = $random(seed);
    write_word(addr & ~axil_addr_t'(1), data, '1, 0, 0, 1'b0);
    check_read(addr | axil_addr_t'(1), 1'b0);
    check_read(addr & ~axil_addr_t'(1), 1'b0);
    finish_test("low address bits ignored", err_start);

    err_start = errors;
    // reads use words 0..15 and writes use words 512..527
    for (i = 0; i < 16; i++) begin
      data = $random(seed);
      write_word(axil_addr_t'(i * 2), data, '1, 0, 0, 1'b0);
      data = $random(seed);
      write_word(axil_addr_t'(12'h400 + i * 2), data, '1, 0, 0, 1'b0);
    end
    fork
      begin
        for (j = 0; j < 20; j++) begin
          waddr = 12'h400 + ($random(seed) & 31);
          wdat  = $random(seed);
          wstrb = $random(seed);
          write_word(waddr, wdat, wstrb, $random(seed) & 3, $random(seed) & 3, 1'b1);
        end
      end
      begin
        for (k = 0; k < 20; k++) begin
          check_read(axil_addr_t'($random(seed) & 31), 1'b1);
        end
      end
    join
    for (i = 0; i < 16; i++) begin
      check_read(axil_addr_t'(12'h400 + i * 2), 1'b0);
    end
    finish_test("random overlap with gaps", err_start);

    err_start = errors;
    n0   = b_count;
    addr = $random(seed);
    data = $random(seed);
    write_word(addr, data, '1, 0, 4, 1'b0);
    repeat (4) @(negedge clk);
    assert (b_count == n0 + 1 && !o_bvalid)
      else report_fail("AW before W did not give exactly one B");
    check_read(addr, 1'b0);
    n0   = b_count;
    addr = $random(seed);
    data = $random(seed);
    write_word(addr, data, '1, 4, 0, 1'b0);
    repeat (4) @(negedge clk);
    assert (b_count == n0 + 1 && !o_bvalid)
      else report_fail("W before AW did not give exactly one B");
    check_read(addr, 1'b0);
    finish_test("AW and W order", err_start);

    $display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== axil_sram.f ====
+incdir+common
common/axil_pkg.sv
common/sram_pkg.sv
axil_sram_bridge/axil_write_path.sv
axil_sram_bridge/axil_read_path.sv
axil_sram_bridge/sram_arbiter.sv
hdl/sram_model.sv
hdl/axil_sram_top.sv
sim/tb_axil_sram.sv
